// ==== logic/calc_controller.sv ====
module calc_controller
    import calc_pkg::*;
(
    input  logic              clk,
    input  logic              nRST,
    input  logic [3:0]        keypad_input,
    input  logic              read_input,
    input  calc_op_t          operator_input,
    input  logic              equal_input,
    output operand_pair_t     add_req,
    output logic              sub,
    output logic              add_start,
    output operand_pair_t     mul_req,
    output logic              mul_start,
    input  logic [DATA_W-1:0] add_result,
    input  logic              add_finish,
    input  logic [DATA_W-1:0] mul_result,
    input  logic              mul_finish,
    output logic              ready,
    output logic              complete,
    output logic [DATA_W-1:0] display_output
);
    typedef enum logic [2:0] {
        ENTER_A,        // First operand digits
        ENTER_B,        // Second operand digits
        SCALE,          // Operand x10 plus held digit
        DISPATCH,       // Start the selected unit
        WAIT_RESULT,
        SHOW            // Result on display, complete high
    } state_t;

    localparam logic [DATA_W-1:0] TEN = DATA_W'(10);

    state_t            state;
    state_t            next_state;
    logic              entering_b;      // Operand currently being built
    calc_op_t          op_q;            // Latched operator
    logic [DATA_W-1:0] operand_a;
    logic [DATA_W-1:0] operand_b;
    logic [DATA_W-1:0] cur_operand;
    logic [DATA_W-1:0] scaled_sum;
    logic [3:0]        digit_q;
    logic              scale_issued;    // x10 multiply already started
    logic              op_legal;
    logic              digit_take;
    logic              op_take;
    logic              eq_take;
    logic              issue_scale;
    logic              unit_finish;
    logic [DATA_W-1:0] unit_result;

    assign ready = (state == ENTER_A) || (state == ENTER_B);

    // Priority is digit, then operator, then equal
    assign op_legal    = operator_input inside {OP_ADD, OP_SUB, OP_MUL};
    assign digit_take  = ready & read_input;
    assign op_take     = ready & ~read_input & op_legal;
    assign eq_take     = (state == ENTER_B) & ~read_input & ~op_legal & equal_input;
    assign issue_scale = (state == SCALE) & ~scale_issued;

    assign cur_operand = entering_b ? operand_b : operand_a;
    assign scaled_sum  = mul_result + DATA_W'(digit_q);    // operand*10 + digit

    assign unit_finish = (op_q == OP_MUL) ? mul_finish : add_finish;
    assign unit_result = (op_q == OP_MUL) ? mul_result : add_result;

    always_comb begin
        next_state = state;
        case (state)
            ENTER_A, ENTER_B: begin
                if (digit_take) begin
                    next_state = SCALE;
                end else if (op_take) begin
                    next_state = ENTER_B;
                end else if (eq_take) begin
                    next_state = DISPATCH;
                end
            end
            SCALE: begin
                if (mul_finish) begin
                    next_state = entering_b ? ENTER_B : ENTER_A;
                end
            end
            DISPATCH: begin
                next_state = WAIT_RESULT;
            end
            WAIT_RESULT: begin
                if (unit_finish) begin
                    next_state = SHOW;
                end
            end
            SHOW: begin
                next_state = ENTER_A;
            end
            default: begin
                next_state = ENTER_A;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= ENTER_A;
            entering_b     <= 1'b0;
            op_q           <= OP_ADD;
            operand_a      <= '0;
            operand_b      <= '0;
            scale_issued   <= 1'b0;
            add_start      <= 1'b0;
            mul_start      <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            state     <= next_state;
            add_start <= 1'b0;    // Strobes last one cycle
            mul_start <= 1'b0;
            complete  <= 1'b0;
            case (state)
                ENTER_A, ENTER_B: begin
                    if (op_take) begin
                        op_q       <= operator_input;
                        entering_b <= 1'b1;
                    end
                end
                SCALE: begin
                    if (issue_scale) begin
                        mul_start    <= 1'b1;
                        scale_issued <= 1'b1;
                    end
                    if (mul_finish) begin
                        scale_issued <= 1'b0;
                        if (entering_b) begin
                            operand_b <= scaled_sum;
                        end else begin
                            operand_a <= scaled_sum;
                        end
                    end
                end
                DISPATCH: begin
                    if (op_q == OP_MUL) begin
                        mul_start <= 1'b1;
                    end else begin
                        add_start <= 1'b1;
                    end
                end
                WAIT_RESULT: begin
                    if (unit_finish) begin
                        display_output <= unit_result;
                        complete       <= 1'b1;
                    end
                end
                SHOW: begin
                    operand_a  <= '0;    // Fresh calculation afterwards
                    operand_b  <= '0;
                    entering_b <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    // Request words are loaded with their start strobe and held
    // until the unit finishes
    always_ff @(posedge clk) begin
        if (digit_take) begin
            digit_q <= keypad_input;
        end
        if (issue_scale) begin
            mul_req <= '{a: cur_operand, b: TEN};
        end
        if (state == DISPATCH) begin
            add_req <= '{a: operand_a, b: operand_b};
            mul_req <= '{a: operand_a, b: operand_b};
            sub     <= (op_q == OP_SUB);
        end
    end

endmodule

// ==== logic/calc_pkg.sv ====
package calc_pkg;

    // All values wrap modulo 2^16 at this width
    localparam int DATA_W = 16;

    // Cycles from a start strobe to the matching finish pulse
    localparam int CALC_LATENCY = 16;

    // One-hot keypad operator codes
    typedef enum logic [2:0] {
        OP_ADD = 3'b001,
        OP_SUB = 3'b010,
        OP_MUL = 3'b100
    } calc_op_t;

    // Request word sent to either arithmetic unit
    typedef struct packed {
        logic [DATA_W-1:0] a;    // First operand
        logic [DATA_W-1:0] b;    // Second operand
    } operand_pair_t;

endpackage

// ==== logic/calculator_top.sv ====
module calculator_top
    import calc_pkg::*;
(
    input  logic              clk,
    input  logic              nRST,
    input  logic [3:0]        keypad_input,
    input  logic              read_input,
    input  logic [2:0]        operator_input,    // Only one-hot codes are accepted
    input  logic              equal_input,
    output logic              ready,
    output logic              complete,
    output logic [DATA_W-1:0] display_output
);
    operand_pair_t     add_req;
    operand_pair_t     mul_req;
    logic              sub;
    logic              add_start;
    logic              add_finish;
    logic              mul_start;
    logic              mul_finish;
    logic [DATA_W-1:0] add_result;
    logic [DATA_W-1:0] mul_result;

    calc_controller ctrl0 (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (calc_op_t'(operator_input)),
        .equal_input    (equal_input),
        .add_req        (add_req),
        .sub            (sub),
        .add_start      (add_start),
        .mul_req        (mul_req),
        .mul_start      (mul_start),
        .add_result     (add_result),
        .add_finish     (add_finish),
        .mul_result     (mul_result),
        .mul_finish     (mul_finish),
        .ready          (ready),
        .complete       (complete),
        .display_output (display_output)
    );

    serial_add_sub add0 (
        .clk    (clk),
        .nRST   (nRST),
        .req    (add_req),
        .sub    (sub),
        .start  (add_start),
        .result (add_result),
        .finish (add_finish)
    );

    // Also does the x10 step of digit entry
    shift_add_multiplier mul0 (
        .clk    (clk),
        .nRST   (nRST),
        .req    (mul_req),
        .start  (mul_start),
        .result (mul_result),
        .finish (mul_finish)
    );

endmodule

// ==== logic/serial_add_sub.sv ====
module serial_add_sub
    import calc_pkg::*;
(
    input  logic              clk,
    input  logic              nRST,
    input  operand_pair_t     req,
    input  logic              sub,
    input  logic              start,
    output logic [DATA_W-1:0] result,
    output logic              finish
);
    localparam int CNT_W = $clog2(CALC_LATENCY);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(CALC_LATENCY - 1);

    logic              busy;
    logic [CNT_W-1:0]  bit_cnt;     // Index of the bit pair being summed
    logic              carry;
    logic [DATA_W-1:0] a_sh;
    logic [DATA_W-1:0] b_sh;
    logic [DATA_W-1:0] sum_sh;
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic              cin;
    logic              sum_bit;
    logic              cout;
    logic              step;

    assign step = busy | start;    // Start is ignored while busy

    // Bit 0 is taken straight from the request in the start cycle,
    // later bits come out of the shift registers
    always_comb begin
        if (busy) begin
            op_a = a_sh;
            op_b = b_sh;
            cin  = carry;
        end else begin
            op_a = req.a;
            op_b = sub ? ~req.b : req.b;    // Two's complement via inverted b
            cin  = sub;                     // Plus one for subtraction
        end
    end

    assign sum_bit = op_a[0] ^ op_b[0] ^ cin;
    assign cout    = (op_a[0] & op_b[0]) | (cin & (op_a[0] ^ op_b[0]));

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            carry   <= 1'b0;
            finish  <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (step) begin
                carry <= cout;
                if (bit_cnt == LAST_BIT) begin
                    busy    <= 1'b0;
                    bit_cnt <= '0;
                    finish  <= 1'b1;    // Sum complete next cycle
                end else begin
                    busy    <= 1'b1;
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            a_sh   <= op_a >> 1;
            b_sh   <= op_b >> 1;
            sum_sh <= {sum_bit, sum_sh[DATA_W-1:1]};    // LSB first, enters at top
        end
    end

    assign result = sum_sh;

endmodule

// ==== logic/shift_add_multiplier.sv ====
module shift_add_multiplier
    import calc_pkg::*;
(
    input  logic              clk,
    input  logic              nRST,
    input  operand_pair_t     req,
    input  logic              start,
    output logic [DATA_W-1:0] result,
    output logic              finish
);
    localparam int CNT_W = $clog2(CALC_LATENCY);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(CALC_LATENCY - 1);

    logic              busy;
    logic [CNT_W-1:0]  step_cnt;
    logic [DATA_W-1:0] mcand;       // Multiplicand, shifts left
    logic [DATA_W-1:0] mplier;      // Multiplier, shifts right
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] op_mcand;
    logic [DATA_W-1:0] op_mplier;
    logic [DATA_W-1:0] op_acc;
    logic [DATA_W-1:0] partial;
    logic              step;

    assign step = busy | start;

    // First step runs on the request in the start cycle
    always_comb begin
        if (busy) begin
            op_mcand  = mcand;
            op_mplier = mplier;
            op_acc    = acc;
        end else begin
            op_mcand  = req.a;
            op_mplier = req.b;
            op_acc    = '0;
        end
    end

    assign partial = op_mplier[0] ? op_mcand : '0;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            finish   <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (step) begin
                if (step_cnt == LAST_STEP) begin
                    busy     <= 1'b0;
                    step_cnt <= '0;
                    finish   <= 1'b1;
                end else begin
                    busy     <= 1'b1;
                    step_cnt <= step_cnt + 1'b1;
                end
            end
        end
    end

    // Only the low half of the product is kept, so the upper
    // multiplicand bits simply fall off the top
    always_ff @(posedge clk) begin
        if (step) begin
            acc    <= op_acc + partial;
            mcand  <= op_mcand << 1;
            mplier <= op_mplier >> 1;
        end
    end

    assign result = acc;

endmodule

// ==== project.f ====
logic/calc_pkg.sv
logic/serial_add_sub.sv
logic/shift_add_multiplier.sv
logic/calc_controller.sv
logic/calculator_top.sv
tests/calc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the calculator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module calc_tb \
    -f project.f \
    -o calc_sim

./obj_dir/calc_sim > sim.log 2>&1
cat sim.log

if grep -q "Done: no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// ==== tests/calc_tb.sv ====
module calc_tb
    import calc_pkg::*;
();
    localparam int READY_TIMEOUT = 2 * CALC_LATENCY + 10;
    localparam int DONE_TIMEOUT  = 2 * CALC_LATENCY + 10;

    logic              clk;
    logic              nRST;
    logic [3:0]        keypad_input;
    logic              read_input;
    logic [2:0]        operator_input;
    logic              equal_input;
    logic              ready;
    logic              complete;
    logic [DATA_W-1:0] display_output;

    int                seed;
    int                err_count;
    logic [DATA_W-1:0] exp_result;    // Model answer for the pending equal

    calculator_top dut0 (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .ready          (ready),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    result_check: assert property (@(posedge clk) disable iff (!nRST)
        complete |-> display_output == exp_result)
    else begin
        err_count++;
        $display("MISMATCH at %0t: display_output expected %0d got %0d",
                 $time, $sampled(exp_result), $sampled(display_output));
    end

    complete_pulse: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete)
    else begin
        err_count++;
        $display("At %0t complete stayed high for more than one cycle", $time);
    end

    busy_while_done: assert property (@(posedge clk) disable iff (!nRST)
        complete |-> !ready)
    else begin
        err_count++;
        $display("At %0t ready was high in the same cycle as complete", $time);
    end

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual)
        else begin
            err_count++;
            $display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic abort_run(input string why);
        err_count++;
        $display("Timeout at %0t: %s", $time, why);
        $display("Checks finished with %0d errors", err_count);
        $display("Done: errors found");
        $finish;
    endtask

    // Operands reduced modulo 2^16 just as digit entry reduces them
    function automatic logic [DATA_W-1:0] model_result(input int unsigned a,
                                                       input int unsigned b,
                                                       input logic [2:0] op);
        logic [DATA_W-1:0] ma;
        logic [DATA_W-1:0] mb;
        logic [DATA_W-1:0] r;
        ma = a[DATA_W-1:0];
        mb = b[DATA_W-1:0];
        case (op)
            OP_ADD:  r = ma + mb;
            OP_SUB:  r = ma - mb;    // Wraps in two's complement
            OP_MUL:  r = ma * mb;    // Low half of the product
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic int unsigned rand_number();
        int unsigned ndig;
        int unsigned limit;
        ndig  = 1 + $unsigned($random(seed)) % 5;
        limit = 1;
        repeat (ndig) begin
            limit = limit * 10;
        end
        return $unsigned($random(seed)) % limit;
    endfunction

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready && n < READY_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!ready) abort_run("ready stayed low longer than any operation takes");
    endtask

    // Drives one strobe that must be dropped while busy
    // (1 digit, 2 operator, 3 equal, 0 none)
    task automatic drive_junk(input int which);
        keypad_input   = (which == 1) ? 4'd9 : 4'd0;
        read_input     = (which == 1);
        operator_input = (which == 2) ? 3'(OP_MUL) : 3'b000;
        equal_input    = (which == 3);
    endtask

    // Each strobe kind alone for one cycle
    task automatic apply_junk();
        for (int k = 1; k <= 3; k++) begin
            drive_junk(k);
            @(negedge clk);
        end
        drive_junk(0);
    endtask

    task automatic press_digit(input logic [3:0] d, input logic noisy);
        wait_ready();
        keypad_input = d;
        read_input   = 1'b1;
        @(negedge clk);
        read_input = 1'b0;
        check_value("ready after digit strobe", 0, int'(ready));
        if (noisy) begin
            apply_junk();
        end
    endtask

    task automatic key_in_number(input int unsigned num, input logic noisy);
        int unsigned digits[$];
        do begin
            digits.push_front(num % 10);
            num = num / 10;
        end while (num != 0);
        foreach (digits[i]) begin
            press_digit(4'(digits[i]), noisy);
        end
    endtask

    task automatic press_op(input logic [2:0] op);
        wait_ready();
        operator_input = op;
        @(negedge clk);
        operator_input = 3'b000;
        check_value("ready after operator strobe", 1, int'(ready));
    endtask

    task automatic press_equal(input logic noisy);
        int n;
        wait_ready();
        equal_input = 1'b1;
        @(negedge clk);
        n = 1;
        equal_input = 1'b0;
        if (noisy) begin
            apply_junk();
            n = n + 3;
        end
        while (!complete && n < DONE_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!complete) begin
            abort_run("complete never rose after an equal strobe");
        end else begin
            check_value("equal to complete latency", CALC_LATENCY + 3, n);
        end
    endtask

    task automatic run_calc(input int unsigned a, input logic [2:0] op,
                            input int unsigned b, input logic noisy);
        key_in_number(a, noisy);
        press_op(op);
        key_in_number(b, 1'b0);
        exp_result = model_result(a, b, op);
        press_equal(noisy);
    endtask

    initial begin
        int unsigned a;
        int unsigned b;
        logic [2:0]  op_sel;
        seed           = 32'h9343_13d1;
        err_count      = 0;
        exp_result     = '0;
        nRST           = 1'b0;
        keypad_input   = 4'd0;
        read_input     = 1'b0;
        operator_input = 3'b000;
        equal_input    = 1'b0;
        repeat (3) begin
            @(posedge clk);
        end
        @(negedge clk);
        nRST = 1'b1;
        @(negedge clk);
        check_value("ready after reset", 1, int'(ready));
        check_value("complete after reset", 0, int'(complete));
        check_value("display_output after reset", 0, int'(display_output));

        run_calc(123, OP_ADD, 45, 1'b0);
        run_calc(7, OP_SUB, 12, 1'b0);      // 65531
        run_calc(999, OP_MUL, 999, 1'b0);   // Product overflows 16 bits
        for (int i = 0; i < 6; i++) begin
            a = rand_number();
            b = rand_number();
            run_calc(a, OP_MUL, b, 1'b0);
        end
        for (int i = 0; i < 6; i++) begin
            a = rand_number();
            b = rand_number();
            op_sel = ($unsigned($random(seed)) % 2 == 0) ? 3'(OP_ADD) : 3'(OP_SUB);
            run_calc(a, op_sel, b, 1'b0);
        end

        // Strobes while busy must be dropped
        run_calc(305, OP_SUB, 48, 1'b1);
        run_calc(62, OP_MUL, 1234, 1'b1);

        // Codes that are not one-hot keep the first operand open
        key_in_number(4, 1'b0);
        wait_ready();
        operator_input = 3'b011;
        @(negedge clk);
        operator_input = 3'b111;
        @(negedge clk);
        operator_input = 3'b110;
        @(negedge clk);
        operator_input = 3'b000;
        check_value("ready after illegal operator", 1, int'(ready));
        key_in_number(2, 1'b0);
        press_op(OP_ADD);
        key_in_number(8, 1'b0);
        exp_result = model_result(42, 8, OP_ADD);
        press_equal(1'b0);

        repeat (3) begin
            @(negedge clk);
        end
        $display("Checks finished with %0d errors", err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
